//--- Makefile
# Verilator build and run for the LPIF link testbench

VERILATOR  ?= verilator
TOP        := lpif_link_tb
FILELIST   := compile.f
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Verification failed
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
logic/lpif_pkg.sv
logic/lpif_auto_sync.sv
logic/lpif_field_map.sv
logic/lpif_phy_concat.sv
logic/lpif_link_top.sv
test/lpif_link_props.sv
test/lpif_link_tb.sv

//--- logic/lpif_auto_sync.sv
// LPIF auto-sync
// Delays tx and rx online by programmable counts and builds the
// persistent marker and strobe that go out with every link word

`timescale 1ns/1ps

module lpif_auto_sync
  import lpif_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   reset,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [delay_width-1:0] delay_x_value,
  input  logic [delay_width-1:0] delay_xz_value,
  input  logic [delay_width-1:0] delay_yz_value,
  input  logic                   tx_mrk_userbit,
  input  logic                   tx_stb_userbit,
  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output logic                   tx_auto_mrk_userbit,
  output logic                   tx_auto_stb_userbit
);

  //////////////////////////////////////////////////////////////////////
  // Delay counters
  // Slot 0 tx online, slot 1 rx online, slot 2 strobe enable

  logic [delay_width-1:0] limit [3];
  logic [delay_width-1:0] cnt   [3];
  logic [2:0]             armed;
  logic [2:0]             done;
  logic [2:0]             done_nxt;
  // Level seen high on the previous edge
  logic                   seen_tx;
  logic                   seen_rx;

  always_comb begin
    limit[0] = delay_xz_value;
    limit[1] = delay_x_value;
    limit[2] = delay_yz_value;
    // Counting starts one edge after the first high sample
    armed[0] = tx_online & seen_tx;
    armed[1] = rx_online & seen_rx;
    // Strobe count chains off delayed tx online, drops with tx online
    armed[2] = tx_online & done[0];
    for (int i = 0; i < 3; i++) begin
      // Sticky once reached, cleared when the run level drops
      done_nxt[i] = armed[i] & (done[i] | (cnt[i] == limit[i]));
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      seen_tx <= 1'b0;
      seen_rx <= 1'b0;
      done    <= '0;
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      seen_tx <= tx_online;
      seen_rx <= rx_online;
      done    <= done_nxt;
      for (int i = 0; i < 3; i++) begin
        if (!armed[i]) begin
          cnt[i] <= '0;
        end else if (!done_nxt[i] && cnt[i] != '1) begin
          // Saturate at all ones
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign tx_online_delay = done[0];
  assign rx_online_delay = done[1];

  //////////////////////////////////////////////////////////////////////
  // Persistent marker and strobe

  // Registered so they line up with the delayed online level
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_auto_mrk_userbit <= 1'b0;
      tx_auto_stb_userbit <= 1'b0;
    end else begin
      // One word frames, so marker is set in every word
      tx_auto_mrk_userbit <= done_nxt[0] | tx_mrk_userbit;
      tx_auto_stb_userbit <= done_nxt[2] | tx_stb_userbit;
    end
  end

endmodule

//--- logic/lpif_field_map.sv
// LPIF field map
// Packs the upstream user fields into the link word and splits the
// downstream word back into fields, valid flags held low while offline

`timescale 1ns/1ps

module lpif_field_map
  import lpif_pkg::*;
(
  // Upstream channel
  input  logic [state_width-1:0]  ustrm_state,
  input  logic [protid_width-1:0] ustrm_protid,
  input  logic [data_width-1:0]   ustrm_data,
  input  logic                    ustrm_dvalid,
  input  logic [crc_width-1:0]    ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  // Downstream channel
  output logic [state_width-1:0]  dstrm_state,
  output logic [protid_width-1:0] dstrm_protid,
  output logic [data_width-1:0]   dstrm_data,
  output logic                    dstrm_dvalid,
  output logic [crc_width-1:0]    dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid,
  // Link side
  input  logic                    rx_online_delay,
  output logic [word_width-1:0]   tx_upstream_word,
  input  logic [word_width-1:0]   rx_downstream_word
);

  //////////////////////////////////////////////////////////////////////
  // Upstream pack

  always_comb begin
    tx_upstream_word                             = '0;
    tx_upstream_word[data_lsb +: data_width]     = ustrm_data;
    tx_upstream_word[crc_lsb +: crc_width]       = ustrm_crc;
    tx_upstream_word[state_lsb +: state_width]   = ustrm_state;
    tx_upstream_word[protid_lsb +: protid_width] = ustrm_protid;
    tx_upstream_word[dvalid_bit]                 = ustrm_dvalid;
    tx_upstream_word[crc_valid_bit]              = ustrm_crc_valid;
    tx_upstream_word[valid_bit]                  = ustrm_valid;
  end

  //////////////////////////////////////////////////////////////////////
  // Downstream unpack

  // Payload fields pass straight through
  assign dstrm_data   = rx_downstream_word[data_lsb +: data_width];
  assign dstrm_crc    = rx_downstream_word[crc_lsb +: crc_width];
  assign dstrm_state  = rx_downstream_word[state_lsb +: state_width];
  assign dstrm_protid = rx_downstream_word[protid_lsb +: protid_width];

  // Flags only count once rx is online
  assign dstrm_dvalid    = rx_downstream_word[dvalid_bit] & rx_online_delay;
  assign dstrm_crc_valid = rx_downstream_word[crc_valid_bit] & rx_online_delay;
  assign dstrm_valid     = rx_downstream_word[valid_bit] & rx_online_delay;

endmodule

//--- logic/lpif_link_top.sv
// LPIF slave link top level
// One upstream and one downstream channel over two PHY lanes, with
// auto-sync for online delay, marker and strobe

`timescale 1ns/1ps

module lpif_link_top
  import lpif_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    reset,
  // Control
  input  logic                    tx_online,
  input  logic                    rx_online,
  // PHY lanes
  output logic [lane_width-1:0]   tx_phy0,
  input  logic [lane_width-1:0]   rx_phy0,
  output logic [lane_width-1:0]   tx_phy1,
  input  logic [lane_width-1:0]   rx_phy1,
  // Downstream channel
  output logic [state_width-1:0]  dstrm_state,
  output logic [protid_width-1:0] dstrm_protid,
  output logic [data_width-1:0]   dstrm_data,
  output logic                    dstrm_dvalid,
  output logic [crc_width-1:0]    dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid,
  // Upstream channel
  input  logic [state_width-1:0]  ustrm_state,
  input  logic [protid_width-1:0] ustrm_protid,
  input  logic [data_width-1:0]   ustrm_data,
  input  logic                    ustrm_dvalid,
  input  logic [crc_width-1:0]    ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  // Configuration
  input  logic                    tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  input  logic [delay_width-1:0]  delay_x_value,
  input  logic [delay_width-1:0]  delay_xz_value,
  input  logic [delay_width-1:0]  delay_yz_value
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  logic                  tx_online_delay;
  logic                  rx_online_delay;
  logic                  tx_auto_mrk_userbit;
  logic                  tx_auto_stb_userbit;
  logic [word_width-1:0] tx_upstream_word;
  logic [word_width-1:0] rx_downstream_word;

  //////////////////////////////////////////////////////////////////////
  // Auto sync

  lpif_auto_sync lpif_auto_sync_i (
    .clk_wr              (clk_wr),
    .reset               (reset),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_xz_value      (delay_xz_value),
    .delay_yz_value      (delay_yz_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  // User fields to and from the link word
  lpif_field_map lpif_field_map_i (
    .ustrm_state         (ustrm_state),
    .ustrm_protid        (ustrm_protid),
    .ustrm_data          (ustrm_data),
    .ustrm_dvalid        (ustrm_dvalid),
    .ustrm_crc           (ustrm_crc),
    .ustrm_crc_valid     (ustrm_crc_valid),
    .ustrm_valid         (ustrm_valid),
    .dstrm_state         (dstrm_state),
    .dstrm_protid        (dstrm_protid),
    .dstrm_data          (dstrm_data),
    .dstrm_dvalid        (dstrm_dvalid),
    .dstrm_crc           (dstrm_crc),
    .dstrm_crc_valid     (dstrm_crc_valid),
    .dstrm_valid         (dstrm_valid),
    .rx_online_delay     (rx_online_delay),
    .tx_upstream_word    (tx_upstream_word),
    .rx_downstream_word  (rx_downstream_word)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY interface

  lpif_phy_concat lpif_phy_concat_i (
    .clk_wr              (clk_wr),
    .reset               (reset),
    .tx_online_delay     (tx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_upstream_word    (tx_upstream_word),
    .rx_phy0             (rx_phy0),
    .rx_phy1             (rx_phy1),
    .tx_phy0             (tx_phy0),
    .tx_phy1             (tx_phy1),
    .rx_downstream_word  (rx_downstream_word)
  );

endmodule

//--- logic/lpif_phy_concat.sv
// LPIF two lane PHY concat
// Spreads the link word over two 80 bit lanes around the strobe and
// marker bits, and rebuilds the word from the receive lanes

`timescale 1ns/1ps

module lpif_phy_concat
  import lpif_pkg::*;
(
  input  logic                  clk_wr,
  input  logic                  reset,
  input  logic                  tx_online_delay,
  input  logic                  tx_auto_mrk_userbit,
  input  logic                  tx_auto_stb_userbit,
  input  logic [word_width-1:0] tx_upstream_word,
  input  logic [lane_width-1:0] rx_phy0,
  input  logic [lane_width-1:0] rx_phy1,
  output logic [lane_width-1:0] tx_phy0,
  output logic [lane_width-1:0] tx_phy1,
  output logic [word_width-1:0] rx_downstream_word
);

  // Payload around the strobe, marker on top
  function automatic logic [lane_width-1:0] lane_pack(
    input logic [lane_payload-1:0] payload,
    input logic                    stb,
    input logic                    mrk
  );
    logic [lane_width-1:0] lane;
    lane                                = '0;
    lane[strobe_bit-1:0]                = payload[strobe_bit-1:0];
    lane[strobe_bit]                    = stb;
    lane[marker_bit-1:strobe_bit+1]     = payload[lane_payload-1:strobe_bit];
    lane[marker_bit]                    = mrk;
    return lane;
  endfunction

  // Drop strobe and marker, close the gap
  function automatic logic [lane_payload-1:0] lane_unpack(
    input logic [lane_width-1:0] lane
  );
    return {lane[marker_bit-1:strobe_bit+1], lane[strobe_bit-1:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // TX lanes

  logic [lane_payload-1:0] tx_pay0;
  logic [lane_payload-1:0] tx_pay1;

  assign tx_pay0 = tx_upstream_word[lane_payload-1:0];
  // Upper lane payload padded with zeros
  assign tx_pay1 = {{(lane_payload-lane1_used){1'b0}},
                    tx_upstream_word[word_width-1:lane_payload]};

  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      // Quiet lanes while offline
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= lane_pack(tx_pay0, tx_auto_stb_userbit, tx_auto_mrk_userbit);
      tx_phy1 <= lane_pack(tx_pay1, tx_auto_stb_userbit, tx_auto_mrk_userbit);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // RX lanes

  logic [lane_payload-1:0] rx_pay0;
  logic [lane_payload-1:0] rx_pay1;

  assign rx_pay0 = lane_unpack(rx_phy0);
  assign rx_pay1 = lane_unpack(rx_phy1);

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_downstream_word <= '0;
    end else begin
      // Padding bits of lane 1 are not part of the word
      rx_downstream_word <= {rx_pay1[lane1_used-1:0], rx_pay0};
    end
  end

endmodule

//--- logic/lpif_pkg.sv
// LPIF slave link definitions
// Field widths, link word layout and PHY lane bit positions for the
// full rate, one word per frame configuration

package lpif_pkg;

  // PHY lane
  localparam int lane_width   = 80;
  localparam int strobe_bit   = 1;
  localparam int marker_bit   = 79;
  // Lane bits left over for word payload
  localparam int lane_payload = 78;

  // Link word
  localparam int word_width   = 153;
  // Word bits riding on lane 1, rest of its payload is zero
  localparam int lane1_used   = word_width - lane_payload;

  // User field widths
  localparam int data_width   = 128;
  localparam int crc_width    = 16;
  localparam int state_width  = 4;
  localparam int protid_width = 2;

  // Field offsets inside the link word
  localparam int data_lsb      = 0;
  localparam int crc_lsb       = 128;
  localparam int state_lsb     = 144;
  localparam int protid_lsb    = 148;
  localparam int dvalid_bit    = 150;
  localparam int crc_valid_bit = 151;
  localparam int valid_bit     = 152;

  // Online delay configuration
  localparam int delay_width  = 8;

endpackage

//--- test/lpif_link_props.sv
// LPIF link assertions
// Reset state, tx lane quieting and rx valid gating on the link top

`timescale 1ns/1ps

module lpif_link_props
  import lpif_pkg::*;
(
  input logic                  clk_wr,
  input logic                  reset,
  input logic                  tx_online,
  input logic                  rx_online,
  input logic [lane_width-1:0] tx_phy0,
  input logic [lane_width-1:0] tx_phy1,
  input logic                  dstrm_valid,
  input logic                  dstrm_dvalid,
  input logic                  dstrm_crc_valid
);

  // Flags low on the cycle after a reset edge
  a_reset_flags: assert property (@(posedge clk_wr)
    reset |=> (!dstrm_valid && !dstrm_dvalid && !dstrm_crc_valid))
    else $error("downstream valid flags high after reset");

  // Online drop clears the delayed level, then the lane register
  a_tx_quiet: assert property (@(posedge clk_wr) disable iff (reset)
    !$past(tx_online, 2) |-> (tx_phy0 == '0 && tx_phy1 == '0))
    else $error("tx lanes not zero after tx_online went low");

  // No downstream valid without rx online
  a_rx_gate: assert property (@(posedge clk_wr) disable iff (reset)
    !rx_online |=> !dstrm_valid)
    else $error("dstrm_valid high while rx_online low");

endmodule

bind lpif_link_top lpif_link_props u_props (
  .clk_wr          (clk_wr),
  .reset           (reset),
  .tx_online       (tx_online),
  .rx_online       (rx_online),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1),
  .dstrm_valid     (dstrm_valid),
  .dstrm_dvalid    (dstrm_dvalid),
  .dstrm_crc_valid (dstrm_crc_valid)
);

//--- test/lpif_link_tb.sv
// LPIF slave link testbench
// Directed tests for reset, online delay, lane mapping, user marker and
// strobe bits, rx valid gating and a tx to rx loopback

`timescale 1ns/1ps

module lpif_link_tb
  import lpif_pkg::*;
;

  logic                    clk_wr;
  logic                    reset;
  logic                    tx_online;
  logic                    rx_online;
  logic [lane_width-1:0]   tx_phy0;
  logic [lane_width-1:0]   tx_phy1;
  logic [lane_width-1:0]   rx_phy0;
  logic [lane_width-1:0]   rx_phy1;
  logic [state_width-1:0]  dstrm_state;
  logic [protid_width-1:0] dstrm_protid;
  logic [data_width-1:0]   dstrm_data;
  logic                    dstrm_dvalid;
  logic [crc_width-1:0]    dstrm_crc;
  logic                    dstrm_crc_valid;
  logic                    dstrm_valid;
  logic [state_width-1:0]  ustrm_state;
  logic [protid_width-1:0] ustrm_protid;
  logic [data_width-1:0]   ustrm_data;
  logic                    ustrm_dvalid;
  logic [crc_width-1:0]    ustrm_crc;
  logic                    ustrm_crc_valid;
  logic                    ustrm_valid;
  logic                    tx_mrk_userbit;
  logic                    tx_stb_userbit;
  logic [delay_width-1:0]  delay_x_value;
  logic [delay_width-1:0]  delay_xz_value;
  logic [delay_width-1:0]  delay_yz_value;
  // Loopback select and task driven rx lanes
  logic                    loopback_en;
  logic [lane_width-1:0]   rx_drv0;
  logic [lane_width-1:0]   rx_drv1;
  int                      err_count;
  int                      check_count;
  int                      test_count;

  assign rx_phy0 = loopback_en ? tx_phy0 : rx_drv0;
  assign rx_phy1 = loopback_en ? tx_phy1 : rx_drv1;

  lpif_link_top u_dut (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_phy0         (tx_phy0),
    .rx_phy0         (rx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy1         (rx_phy1),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value)
  );

  // 8 ns clock
  always #4 clk_wr = ~clk_wr;

  //////////////////////////////////////////////////////////////////////
  // Reference model

  // Payload bit 0 at lane bit 0, the rest shifted up past the strobe
  function automatic logic [79:0] model_lane(
    input logic [77:0] pay,
    input logic        stb,
    input logic        mrk
  );
    logic [79:0] lane;
    lane    = '0;
    lane[0] = pay[0];
    for (int i = 1; i < 78; i++) begin
      lane[i+1] = pay[i];
    end
    lane[1]  = stb;
    lane[79] = mrk;
    return lane;
  endfunction

  // Word is valid, crc_valid, dvalid, protid, state, crc, data from the top
  function automatic logic [152:0] dstrm_word();
    return {dstrm_valid, dstrm_crc_valid, dstrm_dvalid, dstrm_protid,
            dstrm_state, dstrm_crc, dstrm_data};
  endfunction

  function automatic logic [152:0] random_word();
    logic [159:0] r;
    r = {$urandom, $urandom, $urandom, $urandom, $urandom};
    return r[152:0];
  endfunction

  task automatic apply_ustrm(input logic [152:0] w);
    ustrm_data      = w[127:0];
    ustrm_crc       = w[143:128];
    ustrm_state     = w[147:144];
    ustrm_protid    = w[149:148];
    ustrm_dvalid    = w[150];
    ustrm_crc_valid = w[151];
    ustrm_valid     = w[152];
  endtask

  // Random strobe and marker bits, the rx side must drop them
  task automatic drive_rx(input logic [152:0] w);
    logic [31:0] r;
    r       = $urandom;
    rx_drv0 = model_lane(w[77:0], r[0], r[1]);
    rx_drv1 = model_lane({3'b000, w[152:78]}, r[2], r[3]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and bounded waits

  task automatic check_value(
    input string        name,
    input logic [159:0] expected,
    input logic [159:0] actual
  );
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("FAILED %0t ns %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("test %-14s %0d errors", name, err_count - errs_before);
  endtask

  // Counts falling edges until tx_phy0[pos] is set, quiet if lanes were zero
  task automatic wait_lane_bit(
    input  int   pos,
    input  int   limit,
    output int   count,
    output logic quiet
  );
    count = 0;
    quiet = 1'b1;
    while (count < limit) begin
      @(negedge clk_wr);
      count++;
      if (tx_phy0[pos]) begin
        break;
      end
      if (tx_phy0 != '0 || tx_phy1 != '0) begin
        quiet = 1'b0;
      end
    end
    if (!tx_phy0[pos]) begin
      err_count++;
      $display("Timeout while waiting for tx lane bit %0d after %0d cycles", pos, limit);
    end
  endtask

  task automatic wait_lanes_quiet(input int limit);
    int count;
    count = 0;
    while ((tx_phy0 != '0 || tx_phy1 != '0) && count < limit) begin
      @(negedge clk_wr);
      count++;
    end
    if (tx_phy0 != '0 || tx_phy1 != '0) begin
      err_count++;
      $display("Timeout while waiting for the tx lanes to go quiet");
    end
  endtask

  task automatic wait_dstrm_valid(input int limit, output int count);
    count = 0;
    while (count < limit) begin
      @(negedge clk_wr);
      count++;
      if (dstrm_valid) begin
        break;
      end
    end
    if (!dstrm_valid) begin
      err_count++;
      $display("Timeout while waiting for dstrm_valid after %0d cycles", limit);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests

  task automatic reset_state_test();
    int errs;
    errs = err_count;
    check_value("tx_phy0", 160'(0), 160'(tx_phy0));
    check_value("tx_phy1", 160'(0), 160'(tx_phy1));
    check_value("dstrm_valid", 160'(0), 160'(dstrm_valid));
    check_value("dstrm_dvalid", 160'(0), 160'(dstrm_dvalid));
    check_value("dstrm_crc_valid", 160'(0), 160'(dstrm_crc_valid));
    report_test("reset_state", errs);
  endtask

  task automatic online_delay_test();
    int           errs;
    int           xz;
    int           yz;
    int           count;
    logic         quiet;
    logic [152:0] w;
    errs = err_count;
    xz   = int'($urandom % 20);
    yz   = int'($urandom % 8);
    w    = random_word();
    @(negedge clk_wr);
    // Live payload while the lanes must stay quiet
    apply_ustrm(w);
    delay_xz_value = 8'(xz);
    delay_yz_value = 8'(yz);
    tx_online      = 1'b1;
    // First sample at the next rising edge, marker xz+2 edges later
    wait_lane_bit(79, 40, count, quiet);
    check_value("marker cycles", 160'(xz + 3), 160'(count));
    check_value("lanes quiet", 160'(1), 160'(quiet));
    check_value("tx_phy0", 160'(model_lane(w[77:0], 1'b0, 1'b1)), 160'(tx_phy0));
    check_value("tx_phy1", 160'(model_lane({3'b000, w[152:78]}, 1'b0, 1'b1)),
                160'(tx_phy1));
    wait_lane_bit(1, 40, count, quiet);
    check_value("strobe cycles", 160'(yz + 1), 160'(count));
    report_test("online_delay", errs);
  endtask

  task automatic tx_mapping_test();
    int           errs;
    logic [152:0] w;
    errs = err_count;
    for (int i = 0; i < 10; i++) begin
      w = random_word();
      apply_ustrm(w);
      @(negedge clk_wr);
      // Marker and strobe enable both on by now
      check_value("tx_phy0", 160'(model_lane(w[77:0], 1'b1, 1'b1)), 160'(tx_phy0));
      check_value("tx_phy1", 160'(model_lane({3'b000, w[152:78]}, 1'b1, 1'b1)),
                  160'(tx_phy1));
    end
    report_test("tx_mapping", errs);
  endtask

  task automatic user_bits_test();
    int   errs;
    int   count;
    logic quiet;
    errs = err_count;
    @(negedge clk_wr);
    tx_online = 1'b0;
    wait_lanes_quiet(6);
    // User bits held while offline stay off the lanes
    tx_mrk_userbit = 1'b1;
    tx_stb_userbit = 1'b1;
    apply_ustrm(random_word());
    repeat (4) begin
      @(negedge clk_wr);
      check_value("tx_phy0 offline", 160'(0), 160'(tx_phy0));
      check_value("tx_phy1 offline", 160'(0), 160'(tx_phy1));
    end
    // Long strobe enable delay so only the user bit drives the strobe
    tx_mrk_userbit = 1'b0;
    delay_xz_value = 8'd2;
    delay_yz_value = 8'd40;
    tx_online      = 1'b1;
    wait_lane_bit(79, 30, count, quiet);
    check_value("marker cycles", 160'(5), 160'(count));
    check_value("lanes quiet", 160'(1), 160'(quiet));
    check_value("strobe user on", 160'(1), 160'(tx_phy0[1]));
    // Two register stages from user bit to lane
    tx_stb_userbit = 1'b0;
    @(negedge clk_wr);
    check_value("strobe held", 160'(1), 160'(tx_phy0[1]));
    @(negedge clk_wr);
    check_value("strobe user off", 160'(0), 160'(tx_phy0[1]));
    tx_stb_userbit = 1'b1;
    repeat (2) @(negedge clk_wr);
    check_value("strobe user back", 160'(1), 160'(tx_phy1[1]));
    tx_stb_userbit = 1'b0;
    report_test("user_bits", errs);
  endtask

  task automatic rx_gating_test();
    int           errs;
    int           x;
    int           count;
    logic [152:0] w;
    errs = err_count;
    x    = int'($urandom % 16);
    @(negedge clk_wr);
    loopback_en   = 1'b0;
    delay_x_value = 8'(x);
    w             = random_word();
    w[152:150]    = 3'b111;
    drive_rx(w);
    // Fields pass, flags held low while rx is offline
    @(negedge clk_wr);
    check_value("dstrm offline", 160'({3'b000, w[149:0]}), 160'(dstrm_word()));
    rx_online = 1'b1;
    wait_dstrm_valid(40, count);
    check_value("rx online cycles", 160'(x + 2), 160'(count));
    check_value("dstrm online", 160'(w), 160'(dstrm_word()));
    for (int i = 0; i < 10; i++) begin
      w = random_word();
      drive_rx(w);
      @(negedge clk_wr);
      check_value("dstrm word", 160'(w), 160'(dstrm_word()));
    end
    report_test("rx_gating", errs);
  endtask

  task automatic loopback_test();
    int           errs;
    logic [152:0] w;
    logic [152:0] expected;
    logic [152:0] sent [$];
    errs = err_count;
    @(negedge clk_wr);
    loopback_en = 1'b1;
    // Tx register then rx register, two cycles end to end
    for (int i = 0; i < 52; i++) begin
      @(negedge clk_wr);
      if (i >= 2) begin
        expected = sent.pop_front();
        check_value("loopback word", 160'(expected), 160'(dstrm_word()));
      end
      if (i < 50) begin
        w = random_word();
        apply_ustrm(w);
        sent.push_back(w);
      end
    end
    report_test("loopback", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(61231));
    err_count      = 0;
    check_count    = 0;
    test_count     = 0;
    clk_wr         = 1'b0;
    reset          = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = 1'b0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = '0;
    delay_xz_value = '0;
    delay_yz_value = '0;
    loopback_en    = 1'b0;
    rx_drv0        = '0;
    rx_drv1        = '0;
    apply_ustrm('0);
    repeat (2) @(posedge clk_wr);
    @(negedge clk_wr);
    reset = 1'b0;
    reset_state_test();
    online_delay_test();
    tx_mapping_test();
    user_bits_test();
    rx_gating_test();
    loopback_test();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Run limit well beyond the whole sequence
  initial begin
    #100000;
    $display("Simulation stopped, run time limit reached");
    $display("Verification failed");
    $finish;
  end

endmodule
